/* include/ecc_cfg.svh */
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

// ####################
// APB bus geometry
// ####################

`define AMBA_WORD        32
`define AMBA_ADDR_WIDTH  20

// ####################
// codec pipeline
// ####################

`define ECC_PIPE_DEPTH   2  // encode stage plus decode stage

// ####################
// register map
// ####################

`define REG_CTRL      20'h00  // op select, a write starts an operation
`define REG_DATA_IN   20'h04
`define REG_CW_WIDTH  20'h08
`define REG_NOISE     20'h0c
`define REG_DATA_OUT  20'h10  // read only
`define REG_STATUS    20'h14  // read only, bit 2 done and bits 1:0 error count

`endif

/* hw/apb_pkg.sv */
`include "ecc_cfg.svh"

package apb_pkg;

  typedef logic [`AMBA_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [`AMBA_WORD-1:0]       apb_data_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } apb_state_e;

  typedef enum logic [2:0] {
    R_CTRL, R_DATA_IN, R_CW_WIDTH, R_NOISE, R_DATA_OUT, R_STATUS, R_NONE
  } apb_reg_e;

  function automatic apb_reg_e reg_of(apb_addr_t addr);
    case (addr)
      `REG_CTRL:     return R_CTRL;
      `REG_DATA_IN:  return R_DATA_IN;
      `REG_CW_WIDTH: return R_CW_WIDTH;
      `REG_NOISE:    return R_NOISE;
      `REG_DATA_OUT: return R_DATA_OUT;
      `REG_STATUS:   return R_STATUS;
      default:       return R_NONE;  // unmapped offsets read as zero
    endcase
  endfunction

endpackage

/* hw/ecc_pkg.sv */
package ecc_pkg;

  typedef logic [31:0] cw_t;
  typedef logic [1:0]  err_cnt_t;
  typedef logic [4:0]  syn_t;  // hamming position or syndrome, positions stay below 32

  typedef enum logic [1:0] {
    OP_ENCODE  = 2'd0,
    OP_DECODE  = 2'd1,
    OP_CHANNEL = 2'd2
  } ecc_op_e;

  typedef enum logic [1:0] {
    CW_8  = 2'd0,
    CW_16 = 2'd1,
    CW_32 = 2'd2
  } cw_width_e;

  // ####################
  // layout helpers
  // ####################

  function automatic int data_bits_of(cw_width_e w);
    case (w)
      CW_8:    return 4;
      CW_16:   return 11;
      default: return 26;  // unknown width codes behave as 32 bit
    endcase
  endfunction

  function automatic int check_bits_of(cw_width_e w);
    case (w)
      CW_8:    return 3;
      CW_16:   return 4;
      default: return 5;
    endcase
  endfunction

  function automatic cw_t cw_mask(cw_width_e w);
    case (w)
      CW_8:    return 32'h0000_00ff;
      CW_16:   return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // j-th hamming position that is not a power of two
  function automatic syn_t ham_pos(int j);
    int   cnt;
    syn_t pos;
    cnt = 0;
    pos = '0;
    for (int p = 3; p < 32; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == j) pos = syn_t'(p);
        cnt++;
      end
    end
    return pos;
  endfunction

endpackage

/* hw/ecc_if.sv */
`timescale 1ns/10ps

interface ecc_req_if;
  import ecc_pkg::*;

  logic      start;  // one cycle pulse, fields valid alongside
  ecc_op_e   op;
  cw_width_e width;
  cw_t       data_in;
  cw_t       noise;

  modport src (output start, op, width, data_in, noise);
  modport dst (input start, op, width, data_in, noise);
endinterface

interface ecc_stage_if;
  import ecc_pkg::*;

  logic      valid;
  ecc_op_e   op;
  cw_width_e width;
  cw_t       word;  // noisy codeword, raw input, or encode result

  modport src (output valid, op, width, word);
  modport dst (input valid, op, width, word);
endinterface

/* hw/apb_ecc_regs.sv */
`timescale 1ns/10ps
`include "ecc_cfg.svh"

module apb_ecc_regs (
  input  logic               clk,
  input  logic               rst,
  input  apb_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  apb_pkg::apb_data_t pwdata,
  output apb_pkg::apb_data_t prdata,
  ecc_req_if.src             req,
  input  logic               res_done,
  input  ecc_pkg::cw_t       res_data,
  input  ecc_pkg::err_cnt_t  res_err,
  output logic               op_done
);
  import apb_pkg::*;
  import ecc_pkg::*;

  apb_state_e state;  // phase seen at the previous edge
  apb_state_e state_nxt;
  apb_reg_e   sel;
  logic       acc_cyc;
  logic       wr_en;
  logic       rd_en;

  logic [1:0] ctrl_q;
  logic [1:0] width_q;
  cw_t        data_in_q;
  cw_t        noise_q;
  cw_t        data_out_q;
  err_cnt_t   err_q;
  logic       done_q;
  logic       start_q;

  // ####################
  // APB slave FSM
  // ####################

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (psel && !penable) state_nxt = SETUP;
      end
      SETUP: begin
        if (psel && penable) state_nxt = ACCESS;
        else if (!psel) state_nxt = IDLE;
      end
      ACCESS: begin
        if (psel && !penable) state_nxt = SETUP;  // back to back transfer
        else state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  assign sel     = reg_of(paddr);
  assign acc_cyc = (state == SETUP) && psel && penable;
  assign wr_en   = acc_cyc && pwrite;
  assign rd_en   = acc_cyc && !pwrite;

  // ####################
  // register file
  // ####################

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      ctrl_q     <= '0;
      width_q    <= '0;
      data_in_q  <= '0;
      noise_q    <= '0;
      data_out_q <= '0;
      err_q      <= '0;
      done_q     <= 1'b0;
      start_q    <= 1'b0;
      prdata     <= '0;
    end else begin
      state   <= state_nxt;
      start_q <= wr_en && (sel == R_CTRL);
      if (wr_en) begin
        case (sel)
          R_CTRL:     ctrl_q    <= pwdata[1:0];
          R_DATA_IN:  data_in_q <= pwdata;
          R_CW_WIDTH: width_q   <= pwdata[1:0];
          R_NOISE:    noise_q   <= pwdata;
          default:    ;  // result registers ignore writes
        endcase
      end
      if (rd_en) begin
        case (sel)
          R_CTRL:     prdata <= apb_data_t'(ctrl_q);
          R_DATA_IN:  prdata <= data_in_q;
          R_CW_WIDTH: prdata <= apb_data_t'(width_q);
          R_NOISE:    prdata <= noise_q;
          R_DATA_OUT: prdata <= data_out_q;
          R_STATUS:   prdata <= apb_data_t'({done_q, err_q});
          default:    prdata <= '0;
        endcase
      end
      if (res_done) begin
        data_out_q <= res_data;
        err_q      <= res_err;
      end
      if (start_q) done_q <= 1'b0;  // a new operation hides the old flag
      else if (res_done) done_q <= 1'b1;
    end
  end

  assign req.start   = start_q;
  assign req.op      = ecc_op_e'(ctrl_q);
  assign req.width   = cw_width_e'(width_q);
  assign req.data_in = data_in_q;
  assign req.noise   = noise_q;
  assign op_done     = done_q;

endmodule

/* hw/ecc_encode_stage.sv */
`timescale 1ns/10ps

module ecc_encode_stage (
  input  logic      clk,
  input  logic      rst,
  ecc_req_if.dst    req,
  ecc_stage_if.src  stg
);
  import ecc_pkg::*;

  int   k;
  int   r;
  cw_t  mask;
  cw_t  code;
  cw_t  word_nxt;
  syn_t chk;

  always_comb begin
    k    = data_bits_of(req.width);
    r    = check_bits_of(req.width);
    mask = cw_mask(req.width);
    chk  = '0;
    for (int j = 0; j < 26; j++) begin
      if (j < k && req.data_in[j]) chk = chk ^ ham_pos(j);
    end
    code = req.data_in & ((cw_t'(1) << k) - cw_t'(1));
    for (int i = 0; i < 5; i++) begin
      if (i < r) code[k + i] = chk[i];  // check bits sit right above the data
    end
    code[k + r] = ^code;  // overall parity on top
    case (req.op)
      OP_ENCODE:  word_nxt = code;
      OP_CHANNEL: word_nxt = code ^ (req.noise & mask);
      default:    word_nxt = req.data_in & mask;  // decode takes the input as a codeword
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stg.valid <= 1'b0;
    end else begin
      stg.valid <= req.start;
    end
  end

  always_ff @(posedge clk) begin
    if (req.start) begin
      stg.op    <= req.op;
      stg.width <= req.width;
      stg.word  <= word_nxt;
    end
  end

endmodule

/* hw/ecc_decode_stage.sv */
`timescale 1ns/10ps

module ecc_decode_stage (
  input  logic              clk,
  input  logic              rst,
  ecc_stage_if.dst          stg,
  output logic              done,
  output ecc_pkg::cw_t      data_out,
  output ecc_pkg::err_cnt_t err_cnt
);
  import ecc_pkg::*;

  int       k;
  int       r;
  cw_t      dmask;
  cw_t      w;
  cw_t      fixed;
  cw_t      data_nxt;
  syn_t     syn;
  logic     par_err;
  err_cnt_t err_nxt;

  // ####################
  // syndrome and parity
  // ####################

  always_comb begin
    k     = data_bits_of(stg.width);
    r     = check_bits_of(stg.width);
    dmask = (cw_t'(1) << k) - cw_t'(1);
    w     = stg.word & cw_mask(stg.width);
    syn   = '0;
    for (int j = 0; j < 26; j++) begin
      if (j < k && w[j]) syn = syn ^ ham_pos(j);
    end
    for (int i = 0; i < 5; i++) begin
      if (i < r && w[k + i]) syn = syn ^ syn_t'(1 << i);
    end
    par_err = ^w;  // parity bit is included, so a clean word gives 0
  end

  // ####################
  // correction
  // ####################

  always_comb begin
    fixed = w;
    for (int j = 0; j < 26; j++) begin
      if (j < k && syn == ham_pos(j)) fixed[j] = ~w[j];
    end
    if (stg.op == OP_ENCODE) begin
      data_nxt = stg.word;
      err_nxt  = 2'd0;
    end else if (par_err) begin
      data_nxt = fixed & dmask;  // syndrome on a check or parity bit leaves data alone
      err_nxt  = 2'd1;
    end else if (syn != '0) begin
      data_nxt = w & dmask;
      err_nxt  = 2'd2;
    end else begin
      data_nxt = w & dmask;
      err_nxt  = 2'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= stg.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stg.valid) begin
      data_out <= data_nxt;
      err_cnt  <= err_nxt;
    end
  end

endmodule

/* hw/ecc_codec_top.sv */
`timescale 1ns/10ps

module ecc_codec_top (
  input  logic               clk,
  input  logic               rst,
  input  apb_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  apb_pkg::apb_data_t pwdata,
  output apb_pkg::apb_data_t prdata,
  output logic               op_done
);
  import ecc_pkg::*;

  ecc_req_if   req_if ();
  ecc_stage_if stg_if ();

  logic     res_done;
  cw_t      res_data;
  err_cnt_t res_err;

  apb_ecc_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .req      (req_if.src),
    .res_done (res_done),
    .res_data (res_data),
    .res_err  (res_err),
    .op_done  (op_done)
  );

  ecc_encode_stage u_enc (
    .clk (clk),
    .rst (rst),
    .req (req_if.dst),
    .stg (stg_if.src)
  );

  ecc_decode_stage u_dec (
    .clk      (clk),
    .rst      (rst),
    .stg      (stg_if.dst),
    .done     (res_done),
    .data_out (res_data),
    .err_cnt  (res_err)
  );

endmodule

/* verif/ecc_codec_props.sv */
`timescale 1ns/10ps
`include "ecc_cfg.svh"

module ecc_codec_props (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic start,
  input logic done,
  input logic op_done
);

  int failures = 0;  // assertion failures seen so far

  // ####################
  // APB protocol
  // ####################

  apb_setup_first: assert property (
    @(posedge clk) disable iff (rst)
    $rose(penable) |-> psel && $past(psel && !penable)
  ) else begin
    failures++;
    $error("penable rose without a preceding SETUP cycle");
  end

  // ####################
  // codec pipeline
  // ####################

  pipe_latency: assert property (
    @(posedge clk) disable iff (rst)
    done == $past(start, `ECC_PIPE_DEPTH)  // each stage takes one cycle and never stalls
  ) else begin
    failures++;
    $error("done does not trail start by the pipeline depth");
  end

  done_clear_on_reset: assert property (
    @(posedge clk)
    $past(rst) |-> !op_done
  ) else begin
    failures++;
    $error("op_done is high right after reset");
  end

endmodule

bind ecc_codec_top ecc_codec_props u_props (
  .clk     (clk),
  .rst     (rst),
  .psel    (psel),
  .penable (penable),
  .start   (req_if.start),
  .done    (res_done),
  .op_done (op_done)
);

/* verif/ecc_codec_tb.sv */
`timescale 1ns/10ps
`include "ecc_cfg.svh"

module ecc_codec_tb;
  import apb_pkg::*;
  import ecc_pkg::*;

  localparam int TIMEOUT     = 50;  // cycles allowed for each wait
  localparam int RANDOM_ROWS = 24;

  typedef struct packed {
    ecc_op_e     op;
    cw_width_e   width;
    logic [31:0] data;
    logic [31:0] noise;
  } row_t;

  logic      clk;
  logic      rst;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      op_done;

  row_t rows[$];
  int   seed       = 32'h2876;
  int   checks     = 0;
  int   mismatches = 0;
  int   timeouts   = 0;

  ecc_codec_top UUT (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .op_done (op_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ####################
  // reference model
  // ####################

  function automatic logic [4:0] ham_position(int j);
    int         seen;
    logic [4:0] pos;
    seen = 0;
    pos  = '0;
    for (int p = 1; p < 32; p++) begin
      if ($countones(p) != 1) begin  // powers of two hold check bits
        if (seen == j) pos = p[4:0];
        seen++;
      end
    end
    return pos;
  endfunction

  function automatic logic [31:0] width_mask(cw_width_e w);
    int          n;
    logic [63:0] m;
    n = data_bits_of(w) + check_bits_of(w) + 1;
    m = (64'd1 << n) - 64'd1;
    return m[31:0];
  endfunction

  function automatic logic [31:0] model_encode(cw_width_e w, logic [31:0] data);
    int          k;
    int          r;
    logic [31:0] cw;
    logic [4:0]  pos;
    logic        c;
    k  = data_bits_of(w);
    r  = check_bits_of(w);
    cw = '0;
    for (int j = 0; j < k; j++) cw[j] = data[j];
    for (int i = 0; i < r; i++) begin
      c = 1'b0;
      for (int j = 0; j < k; j++) begin
        pos = ham_position(j);
        if (pos[i]) c = c ^ data[j];
      end
      cw[k + i] = c;
    end
    cw[k + r] = ^cw;  // overall parity covers data and check bits
    return cw;
  endfunction

  function automatic void model_decode(cw_width_e w, logic [31:0] word,
                                       output logic [31:0] data, output logic [1:0] err);
    int          k;
    int          r;
    logic [31:0] wm;
    logic [4:0]  syn;
    logic [4:0]  pos;
    logic        c;
    k  = data_bits_of(w);
    r  = check_bits_of(w);
    wm = word & width_mask(w);
    for (int i = 0; i < 5; i++) begin
      c = (i < r) ? wm[k + i] : 1'b0;  // received check bit against recomputed one
      for (int j = 0; j < k; j++) begin
        pos = ham_position(j);
        if (i < r && pos[i]) c = c ^ wm[j];
      end
      syn[i] = c;
    end
    data = wm & ((32'd1 << k) - 32'd1);
    if (^wm) begin
      err = 2'd1;
      for (int j = 0; j < k; j++) begin
        if (ham_position(j) == syn) data[j] = ~data[j];
      end
    end else if (syn != '0) begin
      err = 2'd2;
    end else begin
      err = 2'd0;
    end
  endfunction

  // ####################
  // APB and checks
  // ####################

  task automatic apb_write(apb_addr_t addr, apb_data_t data);
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(apb_addr_t addr, output apb_data_t data);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    data    = prdata;  // registered at the ACCESS edge
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("[FAIL] %0t ns %s expected %08h got %08h", $time, name, exp, got);
    end
  endtask

  task automatic read_check(apb_addr_t addr, string name, logic [31:0] exp);
    apb_data_t got;
    apb_read(addr, got);
    check_value(name, got, exp);
  endtask

  task automatic wait_for_done(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (op_done && n < TIMEOUT) begin  // old flag clears when the new op starts
      @(negedge clk);
      n++;
    end
    if (op_done) begin
      timeouts++;
      $display("op_done stayed high after the CTRL write at %0t ns", $time);
      return;
    end
    n = 0;
    while (!op_done && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!op_done) begin
      timeouts++;
      $display("the operation never finished, op_done did not rise by %0t ns", $time);
      return;
    end
    ok = 1'b1;
  endtask

  // ####################
  // table
  // ####################

  function automatic void add_row(ecc_op_e op, cw_width_e w, logic [31:0] d, logic [31:0] n);
    rows.push_back('{op, w, d, n});
  endfunction

  task automatic build_table();
    logic [31:0] rnd;
    logic [31:0] pick;
    logic [31:0] noise;
    ecc_op_e     op;
    cw_width_e   w;
    int          n;
    add_row(OP_ENCODE, CW_8, 32'h0000_000b, '0);
    add_row(OP_ENCODE, CW_16, 32'hffff_f5a5, '0);  // upper data bits are dropped
    add_row(OP_ENCODE, CW_32, 32'hffff_ffff, '0);
    add_row(OP_CHANNEL, CW_8, 32'h0000_0006, '0);
    add_row(OP_CHANNEL, CW_16, 32'h0000_03c1, '0);
    add_row(OP_CHANNEL, CW_32, 32'h0012_3456, '0);
    add_row(OP_CHANNEL, CW_8, 32'h0000_0009, 32'h0000_0004);
    add_row(OP_CHANNEL, CW_16, 32'h0000_07ff, 32'h0000_1000);  // check bit 1
    add_row(OP_CHANNEL, CW_32, 32'h0155_5555, 32'h8000_0000);  // parity bit
    add_row(OP_CHANNEL, CW_8, 32'h0000_0005, 32'h0000_0080);
    add_row(OP_CHANNEL, CW_8, 32'h0000_0003, 32'hffff_ff02);  // noise above width is masked
    add_row(OP_CHANNEL, CW_8, 32'h0000_000a, 32'h0000_0003);
    add_row(OP_CHANNEL, CW_16, 32'h0000_02f0, 32'h0000_4008);
    add_row(OP_CHANNEL, CW_32, 32'h03ff_ffff, 32'h8000_0001);
    add_row(OP_DECODE, CW_16, model_encode(CW_16, 32'h0000_04d2) ^ 32'h0000_0020, '0);
    add_row(OP_DECODE, CW_8, model_encode(CW_8, 32'h0000_0007) ^ 32'hffff_ff02, '0);
    add_row(OP_DECODE, CW_32, model_encode(CW_32, 32'h02a5_5a5a) ^ 32'h0800_0000, '0);
    for (int i = 0; i < RANDOM_ROWS; i++) begin
      rnd   = $random(seed);
      op    = ecc_op_e'(2'(rnd % 3));
      w     = cw_width_e'(2'((rnd >> 8) % 3));
      n     = data_bits_of(w) + check_bits_of(w) + 1;
      noise = '0;
      for (int b = 0; b < 2; b++) begin
        pick = $random(seed);
        if (pick[31]) noise = noise | (32'd1 << (pick[15:0] % n));
      end
      rnd = $random(seed);
      if (op == OP_DECODE) rnd = model_encode(w, rnd) ^ noise;
      add_row(op, w, rnd, noise);
    end
  endtask

  task automatic run_row(int idx, row_t row);
    logic [31:0] exp_data;
    logic [1:0]  exp_err;
    bit          ok;
    case (row.op)
      OP_ENCODE: begin
        exp_data = model_encode(row.width, row.data);
        exp_err  = 2'd0;
      end
      OP_DECODE: model_decode(row.width, row.data, exp_data, exp_err);
      default: model_decode(row.width, model_encode(row.width, row.data) ^
                            (row.noise & width_mask(row.width)), exp_data, exp_err);
    endcase
    apb_write(`REG_DATA_IN, row.data);
    apb_write(`REG_CW_WIDTH, 32'(row.width));
    apb_write(`REG_NOISE, row.noise);
    apb_write(`REG_CTRL, 32'(row.op));
    wait_for_done(ok);
    if (ok) begin
      read_check(`REG_DATA_OUT, $sformatf("data_out row %0d", idx), exp_data);
      read_check(`REG_STATUS, $sformatf("status row %0d", idx), {29'd0, 1'b1, exp_err});
    end
  endtask

  initial begin
    bit ok;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    build_table();
    repeat (4) @(negedge clk);
    rst = 1'b0;

    check_value("op_done", 32'(op_done), 32'd0);
    for (int a = 0; a < 6; a++) begin
      read_check(apb_addr_t'(a * 4), $sformatf("register 0x%02h", a * 4), 32'd0);
    end

    foreach (rows[i]) run_row(i, rows[i]);

    apb_write(`REG_DATA_IN, 32'hdead_beef);
    apb_write(`REG_NOISE, 32'h8000_0001);
    apb_write(`REG_CW_WIDTH, 32'hffff_fffe);
    read_check(`REG_DATA_IN, "data_in", 32'hdead_beef);
    read_check(`REG_NOISE, "noise", 32'h8000_0001);
    read_check(`REG_CW_WIDTH, "cw_width", 32'h0000_0002);
    apb_write(`REG_CTRL, 32'hffff_fff1);
    wait_for_done(ok);
    read_check(`REG_CTRL, "ctrl", 32'h0000_0001);

    $display("checks %0d, value mismatches %0d, timeouts %0d, assertion failures %0d",
             checks, mismatches, timeouts, UUT.u_props.failures);
    if (mismatches == 0 && timeouts == 0 && UUT.u_props.failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
hw/apb_pkg.sv
hw/ecc_pkg.sv
hw/ecc_if.sv
hw/apb_ecc_regs.sv
hw/ecc_encode_stage.sv
hw/ecc_decode_stage.sv
hw/ecc_codec_top.sv
verif/ecc_codec_props.sv
verif/ecc_codec_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= ecc_codec_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
